// ==== Bender.yml ====
package:
  name: lbs_detector

export_include_dirs:
  - .

sources:
  - files:
      - lbs_pixel_pkg.sv
      - lbs_ctrl_pkg.sv
      - lbs_resize.sv
      - lbs_window_mem.sv
      - lbs_classifier.sv
      - lbs_detector.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_checker.sv
      - tb_lbs_detector.sv

// ==== filelist.f ====
+incdir+.
lbs_pixel_pkg.sv
lbs_ctrl_pkg.sv
lbs_resize.sv
lbs_window_mem.sv
lbs_classifier.sv
lbs_detector.sv
tb_clkgen.sv
tb_checker.sv
tb_lbs_detector.sv

// ==== lbs_classifier.sv ====
`timescale 1ns/1ps

`include "lbs_consts.svh"

module lbs_classifier
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_start,
	input  lbs_pixel_pkg::window_t i_window,
	input  logic                   i_feature_valid,
	input  lbs_ctrl_pkg::feature_t i_feature,
	output lbs_ctrl_pkg::verdict_t o_verdict
);

	import lbs_pixel_pkg::*;
	import lbs_ctrl_pkg::*;

	localparam int SW = `SUM_W;

	// Local binary pattern of the eight neighbours around the centre
	function automatic logic [7:0] lbp_code(input window_t w);
		logic [7:0]    code;
		logic [SW-1:0] scaled;
		int            bit_idx;
		code    = '0;
		bit_idx = 0;
		for (int i = 0; i < 9; i++)
		begin
			if (i != 4)
			begin
				scaled        = SW'(w.pix[i]) * SW'(9);
				code[bit_idx] = scaled >= w.sum; // At or above the mean
				bit_idx++;
			end
		end
		return code;
	endfunction

	logic [7:0]                  win_code;
	logic signed [`WEIGHT_W-1:0] score;
	logic signed [`WEIGHT_W-1:0] add_w;
	logic signed [`WEIGHT_W-1:0] score_next;
	logic                        busy;
	logic                        stage_fail;
	verdict_t                    verdict;

	always_comb
	begin
		add_w      = (i_feature.code == win_code) ? i_feature.weight : '0;
		score_next = score + add_w;
		stage_fail = i_feature.stage_end && (score_next < i_feature.threshold);
	end

	////////////////////////////////////////////////////////////
	// Stage scoring
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			win_code <= '0;
			score    <= '0;
			busy     <= 1'b0;
			verdict  <= '0;
		end
		else
		begin
			verdict.done <= 1'b0; // Pulse only
			if (i_start)
			begin
				win_code <= lbp_code(i_window);
				score    <= '0;
				busy     <= 1'b1;
			end
			else if (busy && i_feature_valid)
			begin
				if (stage_fail)
				begin
					busy              <= 1'b0; // Early reject
					verdict.done      <= 1'b1;
					verdict.candidate <= 1'b0;
				end
				else if (i_feature.last)
				begin
					busy              <= 1'b0;
					verdict.done      <= 1'b1;
					verdict.candidate <= 1'b1;
				end
				else if (i_feature.stage_end)
				begin
					score <= '0; // Next stage starts from zero
				end
				else
				begin
					score <= score_next;
				end
			end
		end
	end

	assign o_verdict = verdict;

	// Records only flow between a start and its done
	a_no_record_idle: assert property (@(posedge clk) disable iff (reset)
		i_feature_valid |-> busy);

endmodule

// ==== lbs_consts.svh ====
`ifndef LBS_CONSTS_SVH
`define LBS_CONSTS_SVH

////////////////////////////////////////////////////////////
// Data widths
////////////////////////////////////////////////////////////

`define PIX_W       8   // Pixel value
`define COORD_W     12  // Frame coordinates
`define SUM_W       12  // Nine pixels at full scale fit here
`define WEIGHT_W    10  // Feature weight and stage score

////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////

`define RESIZE_W    8   // Resized frame width
`define RESIZE_H    6   // Resized frame height

// Keep one sample in 2**SCALE_SHIFT per direction
`define SCALE_SHIFT 1

`endif

// ==== lbs_ctrl_pkg.sv ====
`include "lbs_consts.svh"

package lbs_ctrl_pkg;

	// Detector control machine
	typedef enum logic [1:0]
	{
		IDLE    = 2'd0, // After reset, waiting for the first full window
		INSPECT = 2'd1, // Scoring feature records
		REQUEST = 2'd2  // Between inspections, collecting pixels
	} detect_state_e;

	// One record of the feature database
	typedef struct packed
	{
		logic [7:0]                  code;      // Pattern to match
		logic signed [`WEIGHT_W-1:0] weight;    // Added on a match
		logic signed [`WEIGHT_W-1:0] threshold; // Valid on stage_end only
		logic                        stage_end;
		logic                        last;      // Final record of the last stage
	} feature_t;

	// Result of one inspection
	typedef struct packed
	{
		logic done;      // One-cycle pulse
		logic candidate;
	} verdict_t;

endpackage

// ==== lbs_detector.sv ====
`timescale 1ns/1ps

module lbs_detector
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_pixel_valid,
	input  lbs_pixel_pkg::pixel_in_t     i_pixel,
	input  logic                         i_feature_valid,
	input  lbs_ctrl_pkg::feature_t       i_feature,
	output logic                         o_pixel_request,
	output logic                         o_feature_request,
	output lbs_pixel_pkg::resize_coord_t o_resize,
	output lbs_ctrl_pkg::verdict_t       o_verdict
);

	import lbs_pixel_pkg::*;
	import lbs_ctrl_pkg::*;

	detect_state_e state;
	detect_state_e next_state;

	resize_coord_t resize;
	window_t       window;
	verdict_t      verdict;
	logic          reach;
	logic          ready;
	logic          mem_wen;
	logic          wrote;       // A write landed at the last edge
	logic          pending;     // Full window waiting for inspection
	logic          pixel_req;
	logic          feature_fire;

	////////////////////////////////////////////////////////////
	// Control machine
	////////////////////////////////////////////////////////////

	assign pending   = wrote && ready;
	assign pixel_req = (state != INSPECT) && !pending; // Hold off while window is claimed
	assign mem_wen   = i_pixel_valid && reach && pixel_req;

	// Records arriving in the done cycle are dropped
	assign feature_fire = i_feature_valid && (state == INSPECT) && !verdict.done;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE, REQUEST:
			begin
				if (pending)
					next_state = INSPECT;
			end
			INSPECT:
			begin
				if (verdict.done)
					next_state = REQUEST;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			wrote <= 1'b0;
		end
		else
		begin
			state <= next_state;
			wrote <= mem_wen;
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	lbs_resize u_resize
	(
		.i_pixel  (i_pixel),
		.o_resize (resize),
		.o_reach  (reach)
	);

	lbs_window_mem u_window_mem
	(
		.clk      (clk),
		.reset    (reset),
		.i_wen    (mem_wen),
		.i_pixel  (i_pixel),
		.i_resize (resize),
		.o_window (window),
		.o_ready  (ready)
	);

	lbs_classifier u_classifier
	(
		.clk             (clk),
		.reset           (reset),
		.i_start         (pending), // High only on the way into INSPECT
		.i_window        (window),
		.i_feature_valid (feature_fire),
		.i_feature       (i_feature),
		.o_verdict       (verdict)
	);

	assign o_pixel_request   = pixel_req;
	assign o_feature_request = (state == INSPECT);
	assign o_resize          = resize;
	assign o_verdict         = verdict;

	// Pixels are requested again once a verdict is out
	a_request_after_done: assert property (@(posedge clk) disable iff (reset)
		o_verdict.done |=> o_pixel_request && !o_feature_request);

endmodule

// ==== lbs_pixel_pkg.sv ====
`include "lbs_consts.svh"

package lbs_pixel_pkg;

	// Incoming camera sample with its original position
	typedef struct packed
	{
		logic [`PIX_W-1:0]   pixel;
		logic [`COORD_W-1:0] ori_x;
		logic [`COORD_W-1:0] ori_y;
	} pixel_in_t;

	// Position in the decimated frame
	typedef struct packed
	{
		logic [`COORD_W-1:0] resize_x;
		logic [`COORD_W-1:0] resize_y;
	} resize_coord_t;

	// 3x3 neighbourhood, row-major, centre at index 4
	typedef struct packed
	{
		logic [8:0][`PIX_W-1:0] pix;
		logic [`SUM_W-1:0]      sum; // Sum of all nine pixels
	} window_t;

endpackage

// ==== lbs_resize.sv ====
`timescale 1ns/1ps

`include "lbs_consts.svh"

module lbs_resize
(
	input  lbs_pixel_pkg::pixel_in_t     i_pixel,
	output lbs_pixel_pkg::resize_coord_t o_resize,
	output logic                         o_reach
);

	import lbs_pixel_pkg::*;

	localparam int SHIFT = `SCALE_SHIFT;

	// Coordinate bits dropped by decimation
	localparam logic [`COORD_W-1:0] LOW_MASK = (`COORD_W'(1) << SHIFT) - `COORD_W'(1);

	resize_coord_t coord;
	logic          x_kept;
	logic          y_kept;

	always_comb
	begin
		coord.resize_x = i_pixel.ori_x >> SHIFT;
		coord.resize_y = i_pixel.ori_y >> SHIFT;
	end

	// A sample survives when it sits on the decimation grid in both axes
	assign x_kept = (i_pixel.ori_x & LOW_MASK) == '0;
	assign y_kept = (i_pixel.ori_y & LOW_MASK) == '0;

	assign o_resize = coord;
	assign o_reach  = x_kept && y_kept;

endmodule

// ==== lbs_window_mem.sv ====
`timescale 1ns/1ps

`include "lbs_consts.svh"

module lbs_window_mem
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_wen,
	input  lbs_pixel_pkg::pixel_in_t     i_pixel,
	input  lbs_pixel_pkg::resize_coord_t i_resize,
	output lbs_pixel_pkg::window_t       o_window,
	output logic                         o_ready
);

	import lbs_pixel_pkg::*;

	localparam int X_W = $clog2(`RESIZE_W);

	// Line buffers, top holds row y-2 and mid holds row y-1
	logic [`PIX_W-1:0] line_top [`RESIZE_W];
	logic [`PIX_W-1:0] line_mid [`RESIZE_W];

	logic [8:0][`PIX_W-1:0] win;
	logic [`SUM_W-1:0]      sum;
	logic                   ready;

	logic [X_W-1:0]    wr_x;
	logic [`PIX_W-1:0] top_rd;
	logic [`PIX_W-1:0] mid_rd;
	logic [`SUM_W-1:0] col_in_sum;
	logic [`SUM_W-1:0] col_out_sum;
	window_t           window;

	assign wr_x = i_resize.resize_x[X_W-1:0];

	// Rows above the frame read as zero
	assign top_rd = (i_resize.resize_y >= `COORD_W'(2)) ? line_top[wr_x] : '0;
	assign mid_rd = (i_resize.resize_y >= `COORD_W'(1)) ? line_mid[wr_x] : '0;

	assign col_in_sum  = `SUM_W'(top_rd) + `SUM_W'(mid_rd) + `SUM_W'(i_pixel.pixel);
	assign col_out_sum = `SUM_W'(win[0]) + `SUM_W'(win[3]) + `SUM_W'(win[6]);

	////////////////////////////////////////////////////////////
	// Line buffers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (i_wen)
		begin
			line_top[wr_x] <= mid_rd;
			line_mid[wr_x] <= i_pixel.pixel;
		end
	end

	////////////////////////////////////////////////////////////
	// Window shift and running sum
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			win   <= '0;
			sum   <= '0;
			ready <= 1'b0;
		end
		else if (i_wen)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win[r*3]   <= win[r*3+1];
				win[r*3+1] <= win[r*3+2];
			end
			win[2] <= top_rd;       // Newest column on the right
			win[5] <= mid_rd;
			win[8] <= i_pixel.pixel;
			sum    <= sum - col_out_sum + col_in_sum;
			// Full 3x3 block ends at this sample
			ready  <= (i_resize.resize_x >= `COORD_W'(2)) &&
				(i_resize.resize_y >= `COORD_W'(2));
		end
	end

	always_comb
	begin
		window.pix = win;
		window.sum = sum;
	end

	assign o_window = window;
	assign o_ready  = ready;

	// Writes stay inside the resized frame
	a_write_in_frame: assert property (@(posedge clk) disable iff (reset)
		i_wen |-> (i_resize.resize_x < `RESIZE_W) && (i_resize.resize_y < `RESIZE_H));

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

`include "lbs_consts.svh"

module tb_checker
#(
	parameter int N_WIN = 24
)
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_pixel_valid,
	input  lbs_pixel_pkg::pixel_in_t     i_pixel,
	input  logic                         i_pixel_request,
	input  logic                         i_feature_request,
	input  lbs_pixel_pkg::resize_coord_t i_resize,
	input  lbs_ctrl_pkg::verdict_t       i_verdict,
	input  logic [N_WIN-1:0]             i_expect,
	output int                           o_errors,
	output int                           o_dones
);

	import lbs_pixel_pkg::*;
	import lbs_ctrl_pkg::*;

	localparam int SHIFT    = `SCALE_SHIFT;
	localparam int ROW_WINS = `RESIZE_W - 2; // Windows per resized row

	int                  errors = 0;
	int                  dones  = 0;
	int                  starts = 0;
	logic                freq_prev;
	logic                done_prev;
	logic                after_reset; // First sample since reset
	logic [`COORD_W-1:0] last_x; // Original position of the last accepted pixel
	logic [`COORD_W-1:0] last_y;
	logic [`COORD_W-1:0] exp_x;
	logic [`COORD_W-1:0] exp_y;

	// Mid-cycle sampling, all DUT outputs are settled here
	always @(negedge clk)
	begin
		if (reset)
		begin
			freq_prev   = 1'b0;
			done_prev   = 1'b0;
			after_reset = 1'b1;
			last_x      = '1;
			last_y      = '1;
		end
		else
		begin
			if (after_reset && (!i_pixel_request || i_feature_request))
			begin
				$display("Requests were wrong in the first cycle after reset");
				errors++;
			end
			after_reset = 1'b0;
			if (i_pixel_request && i_feature_request)
			begin
				$display("Both request outputs are high at %0t", $time);
				errors++;
			end
			if (i_pixel_valid && i_pixel_request)
			begin
				exp_x = i_pixel.ori_x >> SHIFT;
				exp_y = i_pixel.ori_y >> SHIFT;
				if (i_resize.resize_x !== exp_x || i_resize.resize_y !== exp_y)
				begin
					$display("[ERROR] o_resize got %h expected %h", i_resize, {exp_x, exp_y});
					errors++;
				end
				last_x = i_pixel.ori_x;
				last_y = i_pixel.ori_y;
			end

			////////////////////////////////////////////////////////////
			// Inspection order and verdicts
			////////////////////////////////////////////////////////////
			if (i_feature_request && !freq_prev)
			begin
				exp_x = `COORD_W'((2 + starts % ROW_WINS) << SHIFT); // Kept, raster order
				exp_y = `COORD_W'((2 + starts / ROW_WINS) << SHIFT);
				if (starts >= N_WIN)
				begin
					$display("An inspection started after the last full window");
					errors++;
				end
				else if (last_x !== exp_x || last_y !== exp_y)
				begin
					$display("[ERROR] trigger pixel ori_x/ori_y got %h/%h expected %h/%h",
						last_x, last_y, exp_x, exp_y);
					errors++;
				end
				starts++;
			end
			if (i_verdict.done)
			begin
				if (dones >= starts || dones >= N_WIN)
				begin
					$display("A done pulse came without an open inspection");
					errors++;
				end
				else if (i_verdict.candidate !== i_expect[dones])
				begin
					$display("[ERROR] o_verdict.candidate window %0d got %h expected %h",
						dones, i_verdict.candidate, i_expect[dones]);
					errors++;
				end
				dones++;
			end
			if (done_prev && (!i_pixel_request || i_feature_request))
			begin
				$display("Requests did not return to pixels the cycle after done");
				errors++;
			end
			freq_prev = i_feature_request;
			done_prev = i_verdict.done;
		end
	end

	assign o_errors = errors;
	assign o_dones  = dones;

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen
(
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk   = 1'b0;
		o_reset = 1'b1;
		repeat (2) @(posedge o_clk);
		#5 o_reset = 1'b0;
	end

	always #20 o_clk = ~o_clk; // 40 ns period

endmodule

// ==== tb_lbs_detector.sv ====
`timescale 1ns/1ps

`include "lbs_consts.svh"

module tb_lbs_detector;

	import lbs_pixel_pkg::*;
	import lbs_ctrl_pkg::*;

	localparam int SHIFT      = `SCALE_SHIFT;
	localparam int FRAME_W    = `RESIZE_W << SHIFT;
	localparam int FRAME_H    = `RESIZE_H << SHIFT;
	localparam int N_PIX      = FRAME_W * FRAME_H;
	localparam int N_WIN      = (`RESIZE_W - 2) * (`RESIZE_H - 2);
	localparam int N_FEAT     = 5;
	localparam int IDLE_LIMIT = 64; // Cycles without any request

	logic             clk;
	logic             reset;
	logic             pixel_valid;
	pixel_in_t        pixel;
	logic             feature_valid;
	feature_t         feature;
	logic             pixel_req;
	logic             feature_req;
	resize_coord_t    resize;
	verdict_t         verdict;
	logic [N_WIN-1:0] expect_cand;
	int               check_errors;
	int               dones;

	logic [`PIX_W-1:0] frame [FRAME_H][FRAME_W]; // Original frame, raster order
	feature_t          features [N_FEAT];
	int                pix_idx   = 0;
	int                feat_idx  = 0;
	logic              freq_prev = 1'b0;
	logic              timed_out = 1'b0;
	int                tb_errors = 0;

	tb_clkgen u_clkgen
	(
		.o_clk   (clk),
		.o_reset (reset)
	);

	lbs_detector DUT
	(
		.clk               (clk),
		.reset             (reset),
		.i_pixel_valid     (pixel_valid),
		.i_pixel           (pixel),
		.i_feature_valid   (feature_valid),
		.i_feature         (feature),
		.o_pixel_request   (pixel_req),
		.o_feature_request (feature_req),
		.o_resize          (resize),
		.o_verdict         (verdict)
	);

	tb_checker #(.N_WIN(N_WIN)) u_checker
	(
		.clk               (clk),
		.reset             (reset),
		.i_pixel_valid     (pixel_valid),
		.i_pixel           (pixel),
		.i_pixel_request   (pixel_req),
		.i_feature_request (feature_req),
		.i_resize          (resize),
		.i_verdict         (verdict),
		.i_expect          (expect_cand),
		.o_errors          (check_errors),
		.o_dones           (dones)
	);

	function automatic feature_t make_record(input logic [7:0] code, input int weight,
		input int threshold, input logic stage_end, input logic last);
		feature_t rec;
		rec.code      = code;
		rec.weight    = `WEIGHT_W'(weight);
		rec.threshold = `WEIGHT_W'(threshold);
		rec.stage_end = stage_end;
		rec.last      = last;
		return rec;
	endfunction

	// Reference verdict of the window ending at resized (rx, ry)
	function automatic logic expected_candidate(input int rx, input int ry);
		int         px [9];
		int         sum;
		int         score;
		int         b;
		logic [7:0] code;
		logic       decided;
		logic       result;
		sum = 0;
		for (int i = 0; i < 9; i++)
		begin
			px[i] = frame[(ry - 2 + i / 3) << SHIFT][(rx - 2 + i % 3) << SHIFT];
			sum += px[i];
		end
		b = 0;
		for (int i = 0; i < 9; i++)
		begin
			if (i != 4)
			begin
				code[b] = (9 * px[i] >= sum); // Neighbour at or above the mean
				b++;
			end
		end
		score   = 0;
		decided = 1'b0;
		result  = 1'b0;
		for (int k = 0; k < N_FEAT; k++)
		begin
			if (!decided)
			begin
				if (features[k].code == code)
					score += int'($signed(features[k].weight));
				if (features[k].stage_end)
				begin
					if (score < int'($signed(features[k].threshold)))
						decided = 1'b1; // Rejected
					else if (features[k].last)
					begin
						decided = 1'b1;
						result  = 1'b1;
					end
					else
						score = 0;
				end
			end
		end
		return result;
	endfunction

	task automatic fill_frame();
		for (int y = 0; y < FRAME_H; y++)
			for (int x = 0; x < FRAME_W; x++)
				frame[y][x] = `PIX_W'($urandom);
		// Flat block, every neighbour sits on the mean
		for (int ry = 1; ry <= 3; ry++)
			for (int rx = 1; rx <= 3; rx++)
				frame[ry << SHIFT][rx << SHIFT] = 8'h80;
		// Dark ring around a bright centre
		for (int ry = 2; ry <= 4; ry++)
			for (int rx = 4; rx <= 6; rx++)
				frame[ry << SHIFT][rx << SHIFT] = 8'h00;
		frame[3 << SHIFT][5 << SHIFT] = 8'hF0;
	endtask

	// One clock of both sources, honouring the request levels
	task automatic drive_cycle(output logic drove);
		int x;
		int y;
		@(posedge clk);
		#5;
		drove         = 1'b0;
		pixel_valid   = 1'b0;
		feature_valid = 1'b0;
		if (feature_req && !freq_prev)
			feat_idx = 0; // Database restarts on each new inspection
		freq_prev = feature_req;
		if (pixel_req && pix_idx < N_PIX)
		begin
			y             = pix_idx / FRAME_W;
			x             = pix_idx % FRAME_W;
			pixel.pixel   = frame[y][x];
			pixel.ori_x   = `COORD_W'(x);
			pixel.ori_y   = `COORD_W'(y);
			pixel_valid   = 1'b1;
			drove         = 1'b1;
			pix_idx++;
		end
		if (feature_req && feat_idx < N_FEAT)
		begin
			feature       = features[feat_idx];
			feature_valid = 1'b1;
			drove         = 1'b1;
			feat_idx++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		int   rnd;
		int   count;
		logic drove;
		pixel_valid   = 1'b0;
		pixel         = '0;
		feature_valid = 1'b0;
		feature       = '0;
		rnd = $urandom(32'hbb69_637f);
		fill_frame();

		// Stage 1 lets the flat (FF) and ring (00) codes through
		features[0] = make_record(8'hFF, 50, 0, 1'b0, 1'b0);
		features[1] = make_record(8'h00, 40, 0, 1'b0, 1'b0);
		features[2] = make_record(8'h0F, 5, 30, 1'b1, 1'b0);
		// Stage 2 keeps only the flat code
		features[3] = make_record(8'hFF, 20, 0, 1'b0, 1'b0);
		features[4] = make_record(8'h00, -5, 10, 1'b1, 1'b1);

		for (int k = 0; k < N_WIN; k++)
			expect_cand[k] = expected_candidate(2 + k % (`RESIZE_W - 2), 2 + k / (`RESIZE_W - 2));

		count = 0;
		while (reset && !timed_out)
		begin
			@(posedge clk);
			count++;
			if (count > 10)
			begin
				$display("Reset was never released");
				timed_out = 1'b1;
			end
		end

		count = 0;
		while (pix_idx < N_PIX && !timed_out)
		begin
			drive_cycle(drove);
			count = drove ? 0 : count + 1;
			if (count > IDLE_LIMIT)
			begin
				$display("The DUT requested nothing for %0d cycles", IDLE_LIMIT);
				timed_out = 1'b1;
			end
		end

		count = 0;
		while ((dones < N_WIN || !pixel_req) && !timed_out)
		begin
			drive_cycle(drove);
			count++;
			if (count > IDLE_LIMIT)
			begin
				$display("Timed out waiting for the last verdict");
				timed_out = 1'b1;
			end
		end
		repeat (2) @(posedge clk);

		if (dones != N_WIN)
		begin
			$display("Expected %0d verdicts but saw %0d", N_WIN, dones);
			tb_errors++;
		end
		$display("Errors: %0d from the checker, %0d from the sequence, verdicts %0d of %0d",
			check_errors, tb_errors, dones, N_WIN);
		if (check_errors == 0 && tb_errors == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
